//--- Bender.yml
package:
  name: s16_bus

sources:
  - include_dirs:
      - .
    files:
      - s16_cpu_pkg.sv
      - s16_mem_pkg.sv
      - s16_cpu_cen.sv
      - s16_addr_dec.sv
      - s16_dtack.sv
      - s16_sdram_arb.sv
      - s16_bus_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_s16_bus.sv

//--- s16_addr_dec.sv
// address decoder: classifies each CPU bus cycle as ROM, RAM or other
`timescale 1ns/1ps
`include "s16_bus_params.svh"

module s16_addr_dec (
    input  logic                  clk,
    input  logic                  rst,
    input  s16_cpu_pkg::cpu_bus_t cpu,
    output s16_mem_pkg::region_t  region,
    output logic                  mem_cs
);

    s16_mem_pkg::region_t region_nx;
    logic                 last_as_n;

    // map lookup on the live address
    always_comb begin
        if (cpu.addr <= `S16_ROM_TOP) begin
            // ROM writes are swallowed, no SDRAM cycle for them
            region_nx = cpu.rnw ? s16_mem_pkg::REG_ROM : s16_mem_pkg::REG_OTHER;
        end else if (cpu.addr >= `S16_RAM_BASE && cpu.addr <= `S16_RAM_TOP) begin
            region_nx = s16_mem_pkg::REG_RAM;
        end else begin
            // I/O and holes
            region_nx = s16_mem_pkg::REG_OTHER;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_as_n <= 1'b1;
            region    <= s16_mem_pkg::REG_OTHER;
            mem_cs    <= 1'b0;
        end else begin
            last_as_n <= cpu.as_n;
            if (cpu.as_n) begin
                // bus idle, nothing selected
                region <= s16_mem_pkg::REG_OTHER;
                mem_cs <= 1'b0;
            end else if (last_as_n) begin
                // falling edge of as_n: sample once, hold for the whole cycle
                region <= region_nx;
                mem_cs <= (region_nx != s16_mem_pkg::REG_OTHER);
            end
        end
    end

endmodule

//--- s16_bus.f
+incdir+.
s16_cpu_pkg.sv
s16_mem_pkg.sv
s16_cpu_cen.sv
s16_addr_dec.sv
s16_dtack.sv
s16_sdram_arb.sv
s16_bus_top.sv
tb_s16_bus.sv

//--- s16_bus_params.svh
// bus subsystem constants: CPU clock divide, address map and bus widths
`ifndef S16_BUS_PARAMS_SVH
`define S16_BUS_PARAMS_SVH

// clk cycles per CPU clock
// cpu_cenb sits half way between two cpu_cen pulses
`define S16_CEN_DIV 4

// word address and data widths of the CPU bus
`define S16_AW 23
`define S16_DW 16

// ROM starts at word 0 and ends here (1 MB)
`define S16_ROM_TOP 23'h07_ffff

// work RAM window (64 kB)
`define S16_RAM_BASE 23'h200000
`define S16_RAM_TOP 23'h207fff

// anything outside these windows is I/O or unmapped
// it gets no memory cycle and reads as zero

`endif

//--- s16_bus_top.sv
// bus acknowledge subsystem top: clock enables, decoder, DTACK and SDRAM arbiter
`timescale 1ns/1ps
`include "s16_bus_params.svh"

module s16_bus_top (
    input  logic                  clk,
    input  logic                  rst,
    input  s16_cpu_pkg::cpu_bus_t cpu,
    input  s16_mem_pkg::vid_req_t vid,
    output logic                  vid_ack,
    output s16_mem_pkg::wb_req_t  wb_o,
    input  s16_mem_pkg::wb_rsp_t  wb_i,
    output logic                  dtack_n,
    output logic [`S16_DW-1:0]    rdata
);

    // CPU clock phases
    logic                 cpu_cen;
    logic                 cpu_cenb;
    // decoded access
    s16_mem_pkg::region_t region;
    logic                 mem_cs;
    // memory status back to the DTACK logic
    logic                 rom_ok;
    logic                 ram_ok;
    logic                 bus_busy;

    s16_cpu_cen u_cen (
        .clk      (clk),
        .rst      (rst),
        .cpu_cen  (cpu_cen),
        .cpu_cenb (cpu_cenb)
    );

    s16_addr_dec u_dec (
        .clk    (clk),
        .rst    (rst),
        .cpu    (cpu),
        .region (region),
        .mem_cs (mem_cs)
    );

    s16_dtack u_dtack (
        .clk      (clk),
        .rst      (rst),
        .cpu_cen  (cpu_cen),
        .cpu_cenb (cpu_cenb),
        .as_n     (cpu.as_n),
        .mem_cs   (mem_cs),
        .bus_busy (bus_busy),
        .rom_ok   (rom_ok),
        .ram_ok   (ram_ok),
        .dtack_n  (dtack_n)
    );

    // single SDRAM port shared by CPU and video
    s16_sdram_arb u_arb (
        .clk      (clk),
        .rst      (rst),
        .cpu      (cpu),
        .region   (region),
        .mem_cs   (mem_cs),
        .vid      (vid),
        .vid_ack  (vid_ack),
        .wb_o     (wb_o),
        .wb_i     (wb_i),
        .rom_ok   (rom_ok),
        .ram_ok   (ram_ok),
        .bus_busy (bus_busy),
        .rdata    (rdata)
    );

endmodule

//--- s16_cpu_cen.sv
// CPU clock enable source: cpu_cen and the half period later cpu_cenb
`timescale 1ns/1ps
`include "s16_bus_params.svh"

module s16_cpu_cen (
    input  logic clk,
    input  logic rst,
    output logic cpu_cen,
    output logic cpu_cenb
);

    localparam int CW = $clog2(`S16_CEN_DIV);

    // phase counter, wraps every S16_CEN_DIV clocks
    logic [CW-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt      <= '0;
            cpu_cen  <= 1'b0;
            cpu_cenb <= 1'b0;
        end else begin
            if (cnt == CW'(`S16_CEN_DIV - 1)) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            // both enables are registered so they come out glitch free
            cpu_cen  <= (cnt == CW'(`S16_CEN_DIV - 1));
            // cenb lands exactly half a CPU clock after cen
            cpu_cenb <= (cnt == CW'(`S16_CEN_DIV / 2 - 1));
        end
    end

    // the two phases must never overlap
    assert property (@(posedge clk) disable iff (rst)
        !(cpu_cen && cpu_cenb));

endmodule

//--- s16_cpu_pkg.sv
// CPU side types: one 68000 style bus cycle as seen by the acknowledge logic
`include "s16_bus_params.svh"

package s16_cpu_pkg;

    // one CPU bus cycle
    // strobes are active low as on the real 68000 pins
    typedef struct packed {
        // word address, A23..A1
        logic [`S16_AW-1:0] addr;
        // high for read
        logic               rnw;
        // address strobe
        logic               as_n;
        // upper byte lane
        logic               uds_n;
        // lower byte lane
        logic               lds_n;
        // write data, only meaningful when rnw is low
        logic [`S16_DW-1:0] wdata;
    } cpu_bus_t;

endpackage

//--- s16_dtack.sv
// DTACK generator: bus wait states, SDRAM busy stretch and delay debt recovery
`timescale 1ns/1ps

module s16_dtack (
    input  logic clk,
    input  logic rst,
    input  logic cpu_cen,
    input  logic cpu_cenb,
    input  logic as_n,
    input  logic mem_cs,
    input  logic bus_busy,
    input  logic rom_ok,
    input  logic ram_ok,
    output logic dtack_n
);

    logic       last_as_n;
    logic       dtack_r;
    // [2] first cenb seen, [1] second cenb seen, [0] one clk past [1]
    logic [2:0] wait_sr;
    // one CPU clock of delay owed to the game
    logic       debt;
    // SDRAM has come up
    logic       started;
    logic       sdram_ok;
    logic       early_ok;

    assign sdram_ok = rom_ok && ram_ok;
    // only the first stage set and debt owed
    assign early_ok = debt && (wait_sr == 3'b100);

    // as_n high forces dtack_n high in the same cycle
    assign dtack_n = dtack_r | as_n;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_as_n <= 1'b1;
            dtack_r   <= 1'b1;
            wait_sr   <= 3'b000;
            debt      <= 1'b0;
            started   <= 1'b0;
        end else begin
            last_as_n <= as_n;
            if (sdram_ok) begin
                started <= 1'b1;
            end
            if (as_n || last_as_n) begin
                // idle or first clk of a new cycle
                dtack_r <= 1'b1;
                wait_sr <= 3'b000;
            end else if (dtack_r) begin
                if (cpu_cenb) begin
                    wait_sr[2] <= 1'b1;
                    wait_sr[1] <= wait_sr[2];
                end
                wait_sr[0] <= wait_sr[1];
                if (!mem_cs) begin
                    // I/O, unmapped or ROM write
                    dtack_r <= 1'b0;
                end else begin
                    // stalled past the normal wait point across a CPU clock
                    if (started && !debt && wait_sr[0] && bus_busy && cpu_cen) begin
                        debt <= 1'b1;
                    end
                    if (!bus_busy && (wait_sr[1] || early_ok)) begin
                        dtack_r <= 1'b0;
                        // finished one CPU clock early, debt paid back
                        if (!wait_sr[1]) begin
                            debt <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    // the arbiter must have captured the CPU ack before dtack goes low
    assert property (@(posedge clk) disable iff (rst)
        $fell(dtack_n) && mem_cs |-> !$past(bus_busy));

endmodule

//--- s16_mem_pkg.sv
// memory side types: Wishbone classic request and response, video client, regions
`include "s16_bus_params.svh"

package s16_mem_pkg;

    // where the current CPU access lands
    typedef enum logic [1:0] {
        REG_ROM   = 2'd0,
        REG_RAM   = 2'd1,
        REG_OTHER = 2'd2
    } region_t;

    // Wishbone classic master outputs
    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        logic [1:0]         sel;
        logic [`S16_AW-1:0] adr;
        logic [`S16_DW-1:0] dat_w;
    } wb_req_t;

    // Wishbone slave outputs
    typedef struct packed {
        logic               ack;
        logic [`S16_DW-1:0] dat_r;
    } wb_rsp_t;

    // video fetcher request, held until vid_ack
    typedef struct packed {
        logic               req;
        logic [`S16_AW-1:0] adr;
    } vid_req_t;

endpackage

//--- s16_sdram_arb.sv
// SDRAM port arbiter: CPU first, video second, one Wishbone classic master
`timescale 1ns/1ps
`include "s16_bus_params.svh"

module s16_sdram_arb (
    input  logic                  clk,
    input  logic                  rst,
    input  s16_cpu_pkg::cpu_bus_t cpu,
    input  s16_mem_pkg::region_t  region,
    input  logic                  mem_cs,
    input  s16_mem_pkg::vid_req_t vid,
    output logic                  vid_ack,
    output s16_mem_pkg::wb_req_t  wb_o,
    input  s16_mem_pkg::wb_rsp_t  wb_i,
    output logic                  rom_ok,
    output logic                  ram_ok,
    output logic                  bus_busy,
    output logic [`S16_DW-1:0]    rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CPU,
        ST_VID
    } arb_state_t;

    arb_state_t state;
    // CPU ack already captured for this bus cycle
    logic       cpu_done;
    logic       cpu_pend;
    logic       is_rom;

    assign cpu_pend = mem_cs && !cpu_done;
    assign is_rom   = (region == s16_mem_pkg::REG_ROM);
    // busy from the decode until the ack is in
    assign bus_busy = cpu_pend;
    // video completion, seen in the same cycle as the slave ack
    assign vid_ack  = (state == ST_VID) && wb_i.ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            wb_o     <= '0;
            cpu_done <= 1'b0;
            rom_ok   <= 1'b0;
            ram_ok   <= 1'b0;
        end else begin
            // new bus cycle rearms the CPU request
            if (!mem_cs) begin
                cpu_done <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (cpu_pend) begin
                        state      <= ST_CPU;
                        wb_o.cyc   <= 1'b1;
                        wb_o.stb   <= 1'b1;
                        wb_o.we    <= ~cpu.rnw;
                        wb_o.sel   <= {~cpu.uds_n, ~cpu.lds_n};
                        wb_o.adr   <= cpu.addr;
                        wb_o.dat_w <= cpu.wdata;
                        // data for this region is stale until the ack
                        if (is_rom) begin
                            rom_ok <= 1'b0;
                        end else begin
                            ram_ok <= 1'b0;
                        end
                    end else if (vid.req) begin
                        // video only gets the port when the CPU is quiet
                        state      <= ST_VID;
                        wb_o.cyc   <= 1'b1;
                        wb_o.stb   <= 1'b1;
                        wb_o.we    <= 1'b0;
                        wb_o.sel   <= 2'b11;
                        wb_o.adr   <= vid.adr;
                        wb_o.dat_w <= '0;
                    end
                end
                ST_CPU: begin
                    if (wb_i.ack) begin
                        state    <= ST_IDLE;
                        wb_o.cyc <= 1'b0;
                        wb_o.stb <= 1'b0;
                        cpu_done <= 1'b1;
                        if (is_rom) begin
                            rom_ok <= 1'b1;
                        end else begin
                            ram_ok <= 1'b1;
                        end
                    end
                end
                ST_VID: begin
                    if (wb_i.ack) begin
                        state    <= ST_IDLE;
                        wb_o.cyc <= 1'b0;
                        wb_o.stb <= 1'b0;
                    end
                end
                default: begin
                    state    <= ST_IDLE;
                    wb_o.cyc <= 1'b0;
                    wb_o.stb <= 1'b0;
                end
            endcase
        end
    end

    // CPU read data, zero whenever no memory access is selected
    always_ff @(posedge clk) begin
        if (!mem_cs) begin
            rdata <= '0;
        end else if (state == ST_CPU && wb_i.ack && !wb_o.we) begin
            rdata <= wb_i.dat_r;
        end
    end

    // classic handshake: request frozen until the slave acks
    assert property (@(posedge clk) disable iff (rst)
        wb_o.stb && !wb_i.ack |=> $stable(wb_o));

    assert property (@(posedge clk) disable iff (rst)
        wb_o.stb |-> wb_o.cyc);

endmodule

//--- tb_s16_bus.sv
// testbench for the bus acknowledge subsystem: CPU cycles, video traffic and a Wishbone memory
`timescale 1ns/1ps
`include "s16_bus_params.svh"

module tb_s16_bus;

    localparam int CLK_PERIOD = 20;
    localparam int N_ACC      = 84;

    logic                  clk;
    logic                  rst;
    s16_cpu_pkg::cpu_bus_t cpu;
    s16_mem_pkg::vid_req_t vid;
    logic                  vid_ack;
    s16_mem_pkg::wb_req_t  wb_o;
    s16_mem_pkg::wb_rsp_t  wb_i;
    logic                  dtack_n;
    logic [`S16_DW-1:0]    rdata;

    // memory model contents and the expected RAM image
    logic [15:0] mem [int];
    logic [15:0] shadow [int];
    logic [31:0] mem_rng;
    logic [31:0] vid_rng;
    logic [31:0] cpu_rng;
    int          errors;
    int          checks;
    // state of the access in flight
    logic        cur_mem;
    logic        cur_other;
    logic        cpu_ack_seen;
    logic        vid_ack_q;
    logic        prev_as_n;
    logic [1:0]  cenb_cnt;
    logic        rom_seen;
    logic        ram_seen;
    // one stall across cpu_cen allows one early completion
    logic        credit;

    s16_bus_top dut (
        .clk     (clk),
        .rst     (rst),
        .cpu     (cpu),
        .vid     (vid),
        .vid_ack (vid_ack),
        .wb_o    (wb_o),
        .wb_i    (wb_i),
        .dtack_n (dtack_n),
        .rdata   (rdata)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // preload pattern of the memory model, every address bit matters
    function automatic logic [15:0] fill_word(input logic [22:0] a);
        return a[15:0] ^ {a[6:0], a[22:16], 2'b01} ^ 16'h5a5a;
    endfunction

    function automatic logic [15:0] read_model(input logic [22:0] a);
        return mem.exists(int'(a)) ? mem[int'(a)] : fill_word(a);
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog, 200 clk per planned access
    initial begin
        #(N_ACC * 200 * CLK_PERIOD);
        $display("timeout: the bus cycles did not finish in time, %0d errors so far", errors);
        $display("Simulation failed");
        $finish;
    end

    // tracking of acks, enables and the start-up condition
    always @(posedge clk) begin
        vid_ack_q <= vid_ack;
        prev_as_n <= cpu.as_n;
        if (wb_i.ack && !vid_ack) begin
            cpu_ack_seen <= 1'b1;
            if (cpu.addr <= `S16_ROM_TOP) begin
                rom_seen <= 1'b1;
            end else begin
                ram_seen <= 1'b1;
            end
        end
        // same counting window as the wait register in the DUT
        if (cpu.as_n || prev_as_n) begin
            cenb_cnt <= 2'd0;
        end else if (dut.cpu_cenb && cenb_cnt != 2'd3) begin
            cenb_cnt <= cenb_cnt + 2'd1;
        end
        if (!cpu.as_n && cur_mem && rom_seen && ram_seen && cenb_cnt >= 2'd2
            && !cpu_ack_seen && dut.cpu_cen) begin
            credit <= 1'b1;
        end
    end

    // Wishbone slave with random ack delay of 0 to 6 clk
    initial begin
        logic [15:0] old_word;
        wait (!rst);
        forever begin
            @(posedge clk);
            #1;
            if (wb_o.stb && !wb_i.ack) begin
                mem_rng = xorshift32(mem_rng);
                repeat (mem_rng % 7) begin
                    @(posedge clk);
                    #1;
                end
                if (wb_o.we) begin
                    old_word = read_model(wb_o.adr);
                    mem[int'(wb_o.adr)] = {wb_o.sel[1] ? wb_o.dat_w[15:8] : old_word[15:8],
                                           wb_o.sel[0] ? wb_o.dat_w[7:0] : old_word[7:0]};
                end else begin
                    wb_i.dat_r = read_model(wb_o.adr);
                end
                wb_i.ack = 1'b1;
                @(posedge clk);
                #1;
                wb_i.ack   = 1'b0;
                wb_i.dat_r = '0;
            end
        end
    end

    // video fetcher, raises requests at random and holds them until served
    initial begin
        wait (!rst);
        forever begin
            @(posedge clk);
            #1;
            vid_rng = xorshift32(vid_rng);
            if (vid.req) begin
                if (vid_ack_q) begin
                    vid.req = 1'b0;
                end
            end else if (vid_rng[2:0] < 3'd3) begin
                vid.req = 1'b1;
                vid.adr = {7'h10, vid_rng[31:16]};
            end
        end
    end

    // one CPU bus cycle, as_n stays low until dtack_n falls
    task automatic bus_cycle(input string name, input logic [22:0] addr, input logic rnw,
                             input logic [15:0] wdata, input logic [15:0] exp, input logic chk);
        logic early;
        cur_mem      = (rnw && addr <= `S16_ROM_TOP)
                       || (addr >= `S16_RAM_BASE && addr <= `S16_RAM_TOP);
        cur_other    = !cur_mem;
        cpu_ack_seen <= 1'b0;
        cpu.addr     = addr;
        cpu.rnw      = rnw;
        cpu.wdata    = wdata;
        cpu.as_n     = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (dtack_n);
        if (chk) begin
            checks++;
            assert (rdata == exp) else begin
                errors++;
                $display("MISMATCH %s expected %h actual %h", name, exp, rdata);
            end
        end
        // done at the first cenb, so the stall is paid back
        early = cur_mem && cenb_cnt < 2'd2;
        // the CPU samples dtack_n low on the next edge before it ends the cycle
        @(posedge clk);
        #1;
        if (early) begin
            credit <= 1'b0;
        end
        cpu.as_n = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
    endtask

    // dtack_n stays high while the bus is idle
    assert property (@(posedge clk) disable iff (rst) cpu.as_n |-> dtack_n)
        else begin
            errors++;
            $display("dtack_n was low while as_n was high");
        end

    // non-memory cycles are acknowledged 2 clk after as_n falls
    assert property (@(posedge clk) disable iff (rst)
        $fell(cpu.as_n) && cur_other |-> ##1 dtack_n ##1 !dtack_n)
        else begin
            errors++;
            $display("MISMATCH other_dtack expected 2 clk latency actual different latency");
        end

    // no memory cycle is acknowledged before its Wishbone ack
    assert property (@(posedge clk) disable iff (rst)
        $fell(dtack_n) && cur_mem |-> cpu_ack_seen)
        else begin
            errors++;
            $display("dtack_n fell before the CPU Wishbone ack");
        end

    // a late ack is followed by dtack_n within one CPU clock
    assert property (@(posedge clk) disable iff (rst)
        $rose(cpu_ack_seen) && cur_mem && !cpu.as_n && cenb_cnt >= 2'd2
        |-> ##[1:`S16_CEN_DIV] !dtack_n)
        else begin
            errors++;
            $display("dtack_n did not follow the late Wishbone ack within one CPU clock");
        end

    // without credit the second cpu_cenb is the earliest completion
    assert property (@(posedge clk) disable iff (rst)
        $fell(dtack_n) && cur_mem && !credit |-> cenb_cnt >= 2'd2)
        else begin
            errors++;
            $display("MISMATCH wait_states expected 2 cenb actual %0d", cenb_cnt);
        end

    // an early completion needs a stall after start-up and never comes before the first cenb
    assert property (@(posedge clk) disable iff (rst)
        $fell(dtack_n) && cur_mem && cenb_cnt < 2'd2 |-> credit && cenb_cnt == 2'd1)
        else begin
            errors++;
            $display("early completion without a preceding stall");
        end

    // video completion belongs to the request that is still pending
    assert property (@(posedge clk) disable iff (rst)
        vid_ack |-> vid.req && wb_o.adr == vid.adr)
        else begin
            errors++;
            $display("vid_ack did not match the pending video request");
        end

    initial begin
        logic [22:0] a;
        logic [15:0] d;
        errors       = 0;
        checks       = 0;
        mem_rng      = 32'h4ab35f37;
        vid_rng      = xorshift32(32'h4ab35f37);
        cpu_rng      = xorshift32(vid_rng);
        cpu          = '0;
        cpu.as_n     = 1'b1;
        cpu.rnw      = 1'b1;
        vid          = '0;
        wb_i         = '0;
        cur_mem      = 1'b0;
        cur_other    = 1'b0;
        cpu_ack_seen <= 1'b0;
        credit       <= 1'b0;
        rom_seen     <= 1'b0;
        ram_seen     <= 1'b0;
        rst          = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        bus_cycle("io_read", 23'h300010, 1'b1, 16'h0, 16'h0, 1'b1);
        bus_cycle("rom_write", 23'h000100, 1'b0, 16'hdead, 16'h0, 1'b0);
        bus_cycle("rom_read", 23'h000100, 1'b1, 16'h0, fill_word(23'h000100), 1'b1);
        for (int i = 0; i < 27; i++) begin
            cpu_rng = xorshift32(cpu_rng);
            a = `S16_RAM_BASE + 23'(cpu_rng[3:0]);
            d = cpu_rng[31:16];
            bus_cycle("ram_write", a, 1'b0, d, 16'h0, 1'b0);
            shadow[int'(a)] = d;
            bus_cycle("ram_read", a, 1'b1, 16'h0, shadow[int'(a)], 1'b1);
            cpu_rng = xorshift32(cpu_rng);
            a = 23'(cpu_rng[18:0]);
            if (cpu_rng[31:29] == 3'd0) begin
                bus_cycle("io_read", 23'h400000 | a, 1'b1, 16'h0, 16'h0, 1'b1);
            end else begin
                bus_cycle("rom_read", a, 1'b1, 16'h0, fill_word(a), 1'b1);
            end
        end
        $display("errors %0d, checks %0d", errors, checks);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
